//--- core_pkg.sv
`default_nettype none

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath and memory sizes
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN                  = 32;         // width of every datapath word.
    localparam int REG_ADDR_W            = 5;          // 32 architectural registers.
    localparam int IMEM_WORDS            = 256;        // instruction rom depth in words.
    localparam int IMEM_AW               = 8;          // word index width into the rom.
    localparam logic [XLEN-1:0] PC_STEP  = 'd4;        // bytes between two instructions.
    localparam string IMEM_FILE          = "prog.hex"; // program image read at start-up.

    //////////////////////////////////////////////////////////////////////
    // control field encodings
    //////////////////////////////////////////////////////////////////////
    localparam logic [3:0] ALU_ADD  = 4'd0;  // zero so that a cleared struct adds.
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLL  = 4'd2;
    localparam logic [3:0] ALU_SLT  = 4'd3;
    localparam logic [3:0] ALU_SLTU = 4'd4;
    localparam logic [3:0] ALU_XOR  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_AND  = 4'd9;

    localparam logic [1:0] IMM_I = 2'd0;  // also used by jalr.
    localparam logic [1:0] IMM_U = 2'd1;
    localparam logic [1:0] IMM_B = 2'd2;
    localparam logic [1:0] IMM_J = 2'd3;

    localparam logic [1:0] WB_ALU    = 2'd0;  // alu result.
    localparam logic [1:0] WB_IMM    = 2'd1;  // immediate as is, for lui.
    localparam logic [1:0] WB_PC_IMM = 2'd2;  // pc plus immediate, for auipc.
    localparam logic [1:0] WB_LINK   = 2'd3;  // return address of a jump.

    typedef struct packed {
        logic       rd_we;      // instruction writes rd.
        logic [3:0] alu_op;     // one of the ALU_* codes.
        logic       src_b_imm;  // operand b is the immediate, not rs2.
        logic [1:0] imm_fmt;    // one of the IMM_* codes.
        logic [1:0] wb_sel;     // one of the WB_* codes.
        logic       is_branch;  // conditional branch.
        logic       is_jal;     // pc relative jump.
        logic       is_jalr;    // register indirect jump.
    } ctrl_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // rv32i major opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct3 of the alu group, shared by op and op-imm.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;  // the only legal jalr funct3.

    // funct3 of the branch group.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // add, srl and friends.
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub and sra.

    //////////////////////////////////////////////////////////////////////
    // instruction word seen through each format
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

`default_nettype wire

//--- core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control
    import core_pkg::*;
    import isa_pkg::*;
(
    input  instr_t instr_i,  // word fetched at the current pc.
    output ctrl_t  ctrl_o    // decoded control, all zero for a no-op.
);

    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;

    assign opc = instr_i.r.opcode;  // the r view names every field decode needs.
    assign f3  = instr_i.r.funct3;
    assign f7  = instr_i.r.funct7;

    always_comb begin
        ctrl_o = '0;  // anything not matched below retires without effect.
        case (opc)
            OPC_LUI: begin
                ctrl_o.rd_we   = 1'b1;
                ctrl_o.imm_fmt = IMM_U;
                ctrl_o.wb_sel  = WB_IMM;
            end
            OPC_AUIPC: begin
                ctrl_o.rd_we   = 1'b1;
                ctrl_o.imm_fmt = IMM_U;
                ctrl_o.wb_sel  = WB_PC_IMM;  // reuses the pc relative adder.
            end
            OPC_JAL: begin
                ctrl_o.rd_we   = 1'b1;
                ctrl_o.imm_fmt = IMM_J;
                ctrl_o.wb_sel  = WB_LINK;
                ctrl_o.is_jal  = 1'b1;
            end
            OPC_JALR: begin
                if (f3 == F3_JALR) begin
                    ctrl_o.rd_we     = 1'b1;
                    ctrl_o.alu_op    = ALU_ADD;  // the alu forms rs1 plus offset.
                    ctrl_o.src_b_imm = 1'b1;
                    ctrl_o.imm_fmt   = IMM_I;
                    ctrl_o.wb_sel    = WB_LINK;
                    ctrl_o.is_jalr   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    ctrl_o.imm_fmt   = IMM_B;  // no register write for branches.
                    ctrl_o.is_branch = 1'b1;
                end
            end
            OPC_OP_IMM, OPC_OP: begin
                ctrl_o.rd_we     = 1'b1;
                ctrl_o.src_b_imm = (opc == OPC_OP_IMM);
                ctrl_o.imm_fmt   = IMM_I;
                ctrl_o.wb_sel    = WB_ALU;
                case (f3)
                    F3_ADD_SUB: ctrl_o.alu_op = (opc == OPC_OP && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     ctrl_o.alu_op = ALU_SLL;
                    F3_SLT:     ctrl_o.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl_o.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl_o.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl_o.alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl_o.alu_op = ALU_OR;
                    default:    ctrl_o.alu_op = ALU_AND;  // only F3_AND is left.
                endcase
                // shifts and every register form need a known funct7.
                if ((opc == OPC_OP || f3 == F3_SLL || f3 == F3_SRL_SRA) &&
                    !(f7 == F7_BASE ||
                      (f7 == F7_ALT && (f3 == F3_SRL_SRA ||
                                        (f3 == F3_ADD_SUB && opc == OPC_OP))))) begin
                    ctrl_o = '0;  // reserved encoding, drop to a no-op.
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit
    import core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  ctrl_t           ctrl_i,           // flow change flags of this instruction.
    input  logic            branch_taken_i,   // branch condition already holds.
    input  logic [XLEN-1:0] pc_imm_target_i,  // pc plus immediate, shared with write-back.
    input  logic [XLEN-1:0] jalr_target_i,    // rs1 plus immediate from the alu.
    output logic [XLEN-1:0] pc_o,
    output logic            update_o          // high once instructions retire.
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;

    always_comb begin
        if (ctrl_i.is_jal || branch_taken_i) begin
            pc_d = pc_imm_target_i;                       // both are pc relative.
        end else if (ctrl_i.is_jalr) begin
            pc_d = {jalr_target_i[XLEN-1:1], 1'b0};       // the spec drops bit 0.
        end else begin
            pc_d = pc_q + PC_STEP;                        // fall through.
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q     <= '0;    // execution starts at address zero.
            update_o <= 1'b0;
        end else begin
            pc_q     <= pc_d;
            update_o <= 1'b1;  // one retirement per clock from here on.
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic [XLEN-1:0] pc_i,    // byte address of the instruction.
    output instr_t          instr_o  // word at that address, no latency.
);

    logic [XLEN-1:0] rom [IMEM_WORDS];

    initial begin
        $readmemh(IMEM_FILE, rom);  // program image, one word per line.
    end

    // the two low bits select a byte inside the word and are dropped.
    assign instr_o = rom[pc_i[IMEM_AW+1:2]];

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rd_we_i,
    input  logic [XLEN-1:0]       rd_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;  // every register starts at zero.
            end
        end else if (rd_we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;  // x0 is never written, so it stays zero.
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];  // reads see the value before this edge.
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import core_pkg::*;
    import isa_pkg::*;
(
    input  instr_t          instr_i,
    input  logic [1:0]      imm_fmt_i,  // one of the IMM_* codes.
    output logic [XLEN-1:0] imm_o       // sign extended from instruction bit 31.
);

    always_comb begin
        case (imm_fmt_i)
            IMM_U: imm_o = {instr_i.u.imm_31_12, 12'b0};  // upper twenty bits.
            IMM_B: imm_o = {{19{instr_i.b.imm_12}},
                            instr_i.b.imm_12,
                            instr_i.b.imm_11,
                            instr_i.b.imm_10_5,
                            instr_i.b.imm_4_1,
                            1'b0};                        // offsets are even.
            IMM_J: imm_o = {{11{instr_i.j.imm_20}},
                            instr_i.j.imm_20,
                            instr_i.j.imm_19_12,
                            instr_i.j.imm_11,
                            instr_i.j.imm_10_1,
                            1'b0};
            default: imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
        endcase
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  ctrl_t           ctrl_i,
    input  logic [2:0]      funct3_i,       // branch condition select.
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o  // only ever high for a branch.
);

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic            cond;

    assign op_b  = ctrl_i.src_b_imm ? imm_i : rs2_i;
    assign shamt = op_b[4:0];  // register shifts ignore the upper bits of rs2.
    assign lt_s  = $signed(rs1_i) < $signed(op_b);
    assign lt_u  = rs1_i < op_b;

    //////////////////////////////////////////////////////////////////////
    // arithmetic and logic
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ctrl_i.alu_op)
            ALU_SUB:  result_o = rs1_i - op_b;
            ALU_SLL:  result_o = rs1_i << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result_o = rs1_i ^ op_b;
            ALU_SRL:  result_o = rs1_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(rs1_i) >>> shamt);  // keeps the sign.
            ALU_OR:   result_o = rs1_i | op_b;
            ALU_AND:  result_o = rs1_i & op_b;
            default:  result_o = rs1_i + op_b;  // add, also jalr targets.
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch condition, operand b is rs2 for every branch
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond = (rs1_i == op_b);
            F3_BNE:  cond = (rs1_i != op_b);
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0;  // reserved codes never reach here as branches.
        endcase
    end

    assign branch_taken_o = ctrl_i.is_branch && cond;

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    output logic                  update_o,    // trace below is valid.
    output logic [XLEN-1:0]       pc_o,        // pc of the retiring instruction.
    output logic [XLEN-1:0]       instr_o,     // its instruction word.
    output logic [REG_ADDR_W-1:0] reg_addr_o,  // rd written, zero if none.
    output logic [XLEN-1:0]       reg_data_o   // value written to rd.
);

    logic [XLEN-1:0] pc_q;
    instr_t          instr;
    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] pc_imm;   // one adder for jal, branches and auipc.
    logic [XLEN-1:0] wb_data;

    pc_unit u_pc (
        .clk_i, .rstn_i, .ctrl_i(ctrl), .branch_taken_i(branch_taken),
        .pc_imm_target_i(pc_imm), .jalr_target_i(alu_result),
        .pc_o(pc_q), .update_o(update_o)
    );

    instr_mem u_imem (.pc_i(pc_q), .instr_o(instr));

    core_control u_ctrl (.instr_i(instr), .ctrl_o(ctrl));

    reg_file u_rf (
        .clk_i, .rstn_i,
        .rs1_addr_i(instr.r.rs1), .rs2_addr_i(instr.r.rs2), .rd_addr_i(instr.r.rd),
        .rd_we_i(ctrl.rd_we), .rd_data_i(wb_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    imm_gen u_imm (.instr_i(instr), .imm_fmt_i(ctrl.imm_fmt), .imm_o(imm));

    alu u_alu (
        .ctrl_i(ctrl), .funct3_i(instr.r.funct3), .rs1_i(rs1_data), .rs2_i(rs2_data),
        .imm_i(imm), .result_o(alu_result), .branch_taken_o(branch_taken)
    );

    assign pc_imm = pc_q + imm;

    always_comb begin
        case (ctrl.wb_sel)
            WB_IMM:    wb_data = imm;
            WB_PC_IMM: wb_data = pc_imm;
            WB_LINK:   wb_data = pc_q + PC_STEP;  // return address.
            default:   wb_data = alu_result;
        endcase
    end

    assign pc_o       = pc_q;
    assign instr_o    = instr;
    assign reg_addr_o = (ctrl.rd_we && instr.r.rd != '0) ? instr.r.rd : '0;
    assign reg_data_o = wb_data;

endmodule

`default_nettype wire

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import core_pkg::*;
    import isa_pkg::*;
();

    localparam int T_RESET        = 0;
    localparam int T_TRACE        = 1;
    localparam int T_REGS         = 2;
    localparam int T_X0           = 3;
    localparam int T_BRANCH       = 4;
    localparam int T_JUMP         = 5;
    localparam int N_TESTS        = 6;
    localparam int TIMEOUT_CYCLES = 200;  // upper bound on every wait loop.
    localparam int HOLD_CYCLES    = 20;   // the final loop must keep its pc this long.
    localparam int K_PLAIN        = 0;
    localparam int K_BRANCH       = 1;
    localparam int K_JUMP         = 2;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  update_o;
    logic [XLEN-1:0]       pc_o;
    logic [XLEN-1:0]       instr_o;
    logic [REG_ADDR_W-1:0] reg_addr_o;
    logic [XLEN-1:0]       reg_data_o;

    logic [XLEN-1:0] prog [IMEM_WORDS];  // private copy of the program image.
    logic [XLEN-1:0] mregs [32];         // architectural registers of the model.
    logic [XLEN-1:0] mpc;                // model pc of the next instruction to retire.
    int              err_cnt [N_TESTS];
    int              chk_cnt [N_TESTS];
    string           test_name [N_TESTS];
    int              prev_kind;          // flow kind of the instruction retired last.
    int              hold;               // retirements in a row that kept the pc.
    bit              timed_out;

    core_top u_dut (
        .clk_i(clk_i), .rstn_i(rstn_i), .update_o(update_o), .pc_o(pc_o),
        .instr_o(instr_o), .reg_addr_o(reg_addr_o), .reg_data_o(reg_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;  // 20 ns period.
    end

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input int test, input string sig,
                               input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        chk_cnt[test]++;
        assert (got === exp) else begin
            err_cnt[test]++;
            $display("Mismatch %s: got %h, expected %h (model pc %h)", sig, got, exp, mpc);
        end
    endtask

    task automatic report_test(input int t);
        if (chk_cnt[t] == 0) begin
            err_cnt[t]++;  // a test that never ran counts as failed.
            $display("test %s: FAIL, no check was reached", test_name[t]);
        end else if (err_cnt[t] == 0) begin
            $display("test %s: ok, %0d checks", test_name[t], chk_cnt[t]);
        end else begin
            $display("test %s: FAIL, %0d of %0d checks wrong", test_name[t], err_cnt[t],
                     chk_cnt[t]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model of the instruction set
    //////////////////////////////////////////////////////////////////////
    function automatic logic branch_holds(input logic [2:0] f3,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;  // reserved conditions never branch.
        endcase
    endfunction

    function automatic logic [XLEN-1:0] alu_value(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];  // only five bits of shift amount count.
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    task automatic execute_model(input logic [XLEN-1:0] w, output logic we,
                                 output logic [4:0] rd, output logic [XLEN-1:0] val,
                                 output logic [XLEN-1:0] npc, output int kind);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_u;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic            legal;
        opc   = w[6:0];
        rd    = w[11:7];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = mregs[w[19:15]];
        b     = mregs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'h000};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        we    = 1'b0;
        val   = '0;
        npc   = mpc + 32'd4;  // unknown words fall through as no-ops.
        kind  = K_PLAIN;
        case (opc)
            OPC_LUI: begin
                we  = 1'b1;
                val = imm_u;
            end
            OPC_AUIPC: begin
                we  = 1'b1;
                val = mpc + imm_u;
            end
            OPC_JAL: begin
                we   = 1'b1;
                val  = mpc + 32'd4;
                npc  = mpc + imm_j;
                kind = K_JUMP;
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    we   = 1'b1;
                    val  = mpc + 32'd4;
                    npc  = (a + imm_i) & ~32'd1;  // target bit 0 is always cleared.
                    kind = K_JUMP;
                end
            end
            OPC_BRANCH: begin
                kind = K_BRANCH;
                if (branch_holds(f3, a, b)) begin
                    npc = mpc + imm_b;
                end
            end
            OPC_OP_IMM: begin
                // shift immediates carry a funct7 that has to be one of the two known ones.
                legal = (f3 == F3_SLL) ? (f7 == F7_BASE) :
                        (f3 == F3_SRL_SRA) ? (f7 == F7_BASE || f7 == F7_ALT) : 1'b1;
                if (legal) begin
                    we  = 1'b1;
                    val = alu_value(f3, f3 == F3_SRL_SRA && f7 == F7_ALT, a, imm_i);
                end
            end
            OPC_OP: begin
                legal = (f7 == F7_BASE) ||
                        (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                if (legal) begin
                    we  = 1'b1;
                    val = alu_value(f3, f7 == F7_ALT, a, b);
                end
            end
            default: ;
        endcase
    endtask

    // retires one instruction in the model and compares the trace when observe is set.
    task automatic check_retire(input bit observe);
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] npc;
        logic [XLEN-1:0] word;
        int              kind;
        int              flow_test;
        int              reg_test;
        word      = prog[mpc[IMEM_AW+1:2]];
        flow_test = (prev_kind == K_BRANCH) ? T_BRANCH :
                    (prev_kind == K_JUMP) ? T_JUMP : T_TRACE;  // pc reflects the last one.
        execute_model(word, we, rd, val, npc, kind);
        reg_test  = (kind == K_JUMP) ? T_JUMP :
                    (kind == K_BRANCH) ? T_BRANCH :
                    (we && rd == 5'd0) ? T_X0 : T_REGS;
        if (observe) begin
            check_value(T_TRACE, "update_o", 32'(update_o), 32'd1);
            check_value(flow_test, "pc_o", pc_o, mpc);
            check_value(T_TRACE, "instr_o", instr_o, word);
            check_value(reg_test, "reg_addr_o", 32'(reg_addr_o),
                        (we && rd != 5'd0) ? 32'(rd) : 32'd0);
            if (we) begin
                check_value(reg_test, "reg_data_o", reg_data_o, val);
            end
        end
        if (we && rd != 5'd0) begin
            mregs[rd] = val;  // x0 keeps reading zero.
        end
        hold      = (npc == mpc) ? hold + 1 : 0;
        mpc       = npc;
        prev_kind = kind;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : main_seq
        int waited;
        int cycles;
        int failed;
        int checks;
        int errors;
        rstn_i       = 1'b0;
        timed_out    = 1'b0;
        prev_kind    = K_PLAIN;
        hold         = 0;
        mpc          = '0;
        test_name[T_RESET]  = "reset";
        test_name[T_TRACE]  = "trace";
        test_name[T_REGS]   = "register_writes";
        test_name[T_X0]     = "x0_writes";
        test_name[T_BRANCH] = "branches";
        test_name[T_JUMP]   = "jumps";
        for (int k = 0; k < N_TESTS; k++) begin
            err_cnt[k] = 0;
            chk_cnt[k] = 0;
        end
        for (int k = 0; k < 32; k++) begin
            mregs[k] = '0;
        end
        $readmemh(IMEM_FILE, prog);
        repeat (10) begin
            @(negedge clk_i);
            check_value(T_RESET, "update_o", 32'(update_o), 32'd0);
            check_value(T_RESET, "pc_o", pc_o, '0);
        end
        rstn_i = 1'b1;
        check_retire(1'b0);  // the word at address zero retires before update_o rises.
        @(negedge clk_i);
        check_value(T_RESET, "update_o", 32'(update_o), 32'd1);
        report_test(T_RESET);
        waited = 0;
        while (!update_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (!update_o) begin
            timed_out = 1'b1;
            $display("Timeout: update_o stayed low for %0d cycles after reset", TIMEOUT_CYCLES);
        end else begin
            cycles = 0;
            while (hold < HOLD_CYCLES && cycles < TIMEOUT_CYCLES) begin
                check_retire(1'b1);
                @(negedge clk_i);
                cycles++;
            end
            if (hold < HOLD_CYCLES) begin
                timed_out = 1'b1;
                $display("Timeout: the program never held its final pc within %0d cycles",
                         TIMEOUT_CYCLES);
            end
        end
        for (int t = T_TRACE; t < N_TESTS; t++) begin
            report_test(t);
        end
        failed = 0;
        checks = 0;
        errors = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            checks += chk_cnt[t];
            errors += err_cnt[t];
            failed += (err_cnt[t] != 0) ? 1 : 0;
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 N_TESTS - failed, failed, checks, errors);
        if (failed == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- prog.hex
// one rv32i instruction word per line, in hex, starting at byte address 0x00.
// the comment after each word gives its byte address and assembly.
800000b7 // 00 lui   x1, 0x80000.
00001797 // 04 auipc x15, 0x1.
ffb00113 // 08 addi  x2, x0, -5.
00700193 // 0c addi  x3, x0, 7.
fff12213 // 10 slti  x4, x2, -1.
00713293 // 14 sltiu x5, x2, 7.
fff1c313 // 18 xori  x6, x3, -1.
0701e393 // 1c ori   x7, x3, 0x70.
0f017413 // 20 andi  x8, x2, 0xf0.
00419493 // 24 slli  x9, x3, 4.
0040d513 // 28 srli  x10, x1, 4.
4040d593 // 2c srai  x11, x1, 4.
00310633 // 30 add   x12, x2, x3.
402186b3 // 34 sub   x13, x3, x2.
00f19733 // 38 sll   x14, x3, x15 (only the low five bits of x15 count).
00312833 // 3c slt   x16, x2, x3.
003138b3 // 40 sltu  x17, x2, x3.
0020c933 // 44 xor   x18, x1, x2.
0030d9b3 // 48 srl   x19, x1, x3.
4030da33 // 4c sra   x20, x1, x3.
00316ab3 // 50 or    x21, x2, x3.
00117b33 // 54 and   x22, x2, x1.
00518013 // 58 addi  x0, x3, 5, dropped by x0.
00300bb3 // 5c add   x23, x0, x3.
00310463 // 60 beq   x2, x3, +8, not taken.
01718463 // 64 beq   x3, x23, +8, taken.
00100f93 // 68 addi  x31, x0, 1, skipped.
01719463 // 6c bne   x3, x23, +8, not taken.
00311463 // 70 bne   x2, x3, +8, taken.
00100f93 // 74 skipped.
0021c463 // 78 blt   x3, x2, +8, not taken.
00314463 // 7c blt   x2, x3, +8, taken.
00100f93 // 80 skipped.
00315463 // 84 bge   x2, x3, +8, not taken.
0021d463 // 88 bge   x3, x2, +8, taken.
00100f93 // 8c skipped.
00316463 // 90 bltu  x2, x3, +8, not taken.
0021e463 // 94 bltu  x3, x2, +8, taken.
00100f93 // 98 skipped.
0021f463 // 9c bgeu  x3, x2, +8, not taken.
00317463 // a0 bgeu  x2, x3, +8, taken.
00100f93 // a4 skipped.
00800c6f // a8 jal   x24, +8.
00100f93 // ac skipped.
00dc0ce7 // b0 jalr  x25, 13(x24), odd target 0xb9 lands on 0xb8.
00100f93 // b4 skipped.
0000006f // b8 jal   x0, 0, loops on itself.

//--- all.f
core_pkg.sv
isa_pkg.sv
core_control.sv
pc_unit.sv
instr_mem.sv
reg_file.sv
imm_gen.sv
alu.sv
core_top.sv
tb_core.sv

//--- run.sh
#!/bin/bash
# builds the testbench with verilator, runs it and checks the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f all.f -o tb_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core | tee sim.log
if [ $? -ne 0 ]; then
    echo "simulation run failed"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
